// File: mem_port_pkg.sv
package mem_port_pkg;

    //////////////////////////////
    // bus widths
    //////////////////////////////

    // byte address, same on both sides and on the bus
    typedef logic [31:0] addr_t;

    // one bus data word
    typedef logic [63:0] mem_data_t;

    //////////////////////////////
    // bus encodings
    //////////////////////////////

    // command on the shared memory bus
    typedef enum logic [1:0] {
        BUS_NONE  = 2'b00,
        BUS_LOAD  = 2'b01,
        BUS_STORE = 2'b10
    } bus_command_t;

    // which requester issued an outstanding tag
    typedef enum logic {
        OWNER_INSTR = 1'b0,
        OWNER_DATA  = 1'b1
    } owner_t;

    //////////////////////////////
    // halt sequencing
    //////////////////////////////

    // running, waiting for loads to drain, stopped until reset
    typedef enum logic [1:0] {
        HALT_RUNNING  = 2'b00,
        HALT_DRAINING = 2'b01,
        HALT_DONE     = 2'b10
    } halt_state_t;

endpackage

// File: mem_request_arbiter.sv
`timescale 1ns/1ns

module mem_request_arbiter
    import mem_port_pkg::*;
#(
    parameter int TAG_BITS = 4
) (
    // instruction fetch side
    input  logic                i_req_valid,
    input  addr_t               i_req_addr,
    output logic                i_req_ready,

    // data cache side
    input  logic                d_req_valid,
    input  bus_command_t        d_req_command,
    input  addr_t               d_req_addr,
    input  mem_data_t           d_req_data,
    output logic                d_req_ready,

    // from halt control
    input  logic                fetch_enable,

    // memory bus
    output bus_command_t        mem_command,
    output addr_t               mem_addr,
    output mem_data_t           mem_data,
    input  logic [TAG_BITS-1:0] mem_response,

    // allocation report to the tag tracker
    output logic                alloc_valid,
    output logic [TAG_BITS-1:0] alloc_tag,
    output owner_t              alloc_owner
);

    logic d_grant;
    logic i_grant;
    logic accepted;

    //////////////////////////////
    // grant
    //////////////////////////////

    // data side always first
    assign d_grant = d_req_valid;
    // fetch only when data idle and not halting
    assign i_grant = i_req_valid && !d_req_valid && fetch_enable;

    //////////////////////////////
    // bus drive
    //////////////////////////////

    always_comb begin
        // idle bus by default
        mem_command = BUS_NONE;
        mem_addr    = '0;
        mem_data    = '0;
        if (d_grant) begin
            mem_command = d_req_command;
            mem_addr    = d_req_addr;
            mem_data    = d_req_data;
        end else if (i_grant) begin
            // fetch is always a load, no write data
            mem_command = BUS_LOAD;
            mem_addr    = i_req_addr;
        end
    end

    //////////////////////////////
    // acceptance
    //////////////////////////////

    // nonzero tag back in the same cycle means taken
    assign accepted    = (mem_response != '0);
    assign d_req_ready = d_grant && accepted;
    assign i_req_ready = i_grant && accepted;

    // only loads get a tracked tag, stores are fire and forget
    assign alloc_valid = accepted && (mem_command == BUS_LOAD);
    assign alloc_tag   = mem_response;
    assign alloc_owner = d_grant ? OWNER_DATA : OWNER_INSTR;

endmodule

// File: mem_tag_tracker.sv
`timescale 1ns/1ns

module mem_tag_tracker
    import mem_port_pkg::*;
#(
    parameter int TAG_BITS = 4
) (
    input  logic                clock,
    input  logic                reset,

    // new load accepted by the memory
    input  logic                alloc_valid,
    input  logic [TAG_BITS-1:0] alloc_tag,
    input  owner_t              alloc_owner,

    // returning load data from the memory
    input  logic [TAG_BITS-1:0] mem_resp_tag,
    input  mem_data_t           mem_resp_data,

    // steered returns
    output logic                i_resp_valid,
    output mem_data_t           i_resp_data,
    output logic                d_resp_valid,
    output mem_data_t           d_resp_data,

    // nothing outstanding
    output logic                tracker_empty
);

    // one entry per tag value, tag 0 never allocated
    localparam int DEPTH = 1 << TAG_BITS;

    logic [DEPTH-1:0]  entry_valid;
    owner_t            entry_owner [DEPTH];
    logic [TAG_BITS:0] live_count;

    logic              alloc_new;
    logic              resp_hit;
    owner_t            resp_owner;

    //////////////////////////////
    // lookup
    //////////////////////////////

    // tag 0 carries nothing
    assign alloc_new  = alloc_valid && (alloc_tag != '0);
    // stray tags with no live entry are dropped here
    assign resp_hit   = (mem_resp_tag != '0) && entry_valid[mem_resp_tag];
    assign resp_owner = entry_owner[mem_resp_tag];

    //////////////////////////////
    // return steering
    //////////////////////////////

    // same cycle as the tag, no buffering
    assign i_resp_valid = resp_hit && (resp_owner == OWNER_INSTR);
    assign d_resp_valid = resp_hit && (resp_owner == OWNER_DATA);

    // both sides see the bus word, valid picks the owner
    assign i_resp_data = mem_resp_data;
    assign d_resp_data = mem_resp_data;

    //////////////////////////////
    // entry table
    //////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            entry_valid <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entry_owner[i] <= OWNER_INSTR;
            end
        end else begin
            // free on return first
            if (resp_hit) begin
                entry_valid[mem_resp_tag] <= 1'b0;
            end
            // allocation wins if the memory reuses the tag at once
            if (alloc_new) begin
                entry_valid[alloc_tag] <= 1'b1;
                entry_owner[alloc_tag] <= alloc_owner;
            end
        end
    end

    //////////////////////////////
    // live count
    //////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            live_count <= '0;
        end else begin
            case ({alloc_new, resp_hit})
                2'b10: live_count <= live_count + 1'b1;
                2'b01: live_count <= live_count - 1'b1;
                // alloc and return together, or neither
                default: live_count <= live_count;
            endcase
        end
    end

    // drain condition for halt
    assign tracker_empty = (live_count == '0);

endmodule

// File: mem_halt_control.sv
`timescale 1ns/1ns

module mem_halt_control
    import mem_port_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic halt,
    input  logic tracker_empty,
    input  logic d_req_valid,
    output logic fetch_enable,
    output logic halted
);

    halt_state_t state;
    halt_state_t next_state;

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            HALT_RUNNING: begin
                if (halt) begin
                    next_state = HALT_DRAINING;
                end
            end
            HALT_DRAINING: begin
                // wait for data side idle and every load back
                if (tracker_empty && !d_req_valid) begin
                    next_state = HALT_DONE;
                end
            end
            // sticky until reset
            default: next_state = HALT_DONE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= HALT_RUNNING;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////
    // outputs
    //////////////////////////////

    // fetch cut in the halt cycle itself
    assign fetch_enable = (state == HALT_RUNNING) && !halt;
    assign halted       = (state == HALT_DONE);

endmodule

// File: mem_port.sv
`timescale 1ns/1ns

module mem_port
    import mem_port_pkg::*;
#(
    parameter int TAG_BITS = 4
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                halt,

    // instruction fetch side
    input  logic                i_req_valid,
    input  addr_t               i_req_addr,
    output logic                i_req_ready,
    output logic                i_resp_valid,
    output mem_data_t           i_resp_data,

    // data cache side
    input  logic                d_req_valid,
    input  bus_command_t        d_req_command,
    input  addr_t               d_req_addr,
    input  mem_data_t           d_req_data,
    output logic                d_req_ready,
    output logic                d_resp_valid,
    output mem_data_t           d_resp_data,

    // memory bus
    output bus_command_t        mem_command,
    output addr_t               mem_addr,
    output mem_data_t           mem_data,
    input  logic [TAG_BITS-1:0] mem_response,
    input  mem_data_t           mem_resp_data,
    input  logic [TAG_BITS-1:0] mem_resp_tag,

    // all loads drained after halt
    output logic                halted
);

    // halt control to arbiter
    logic                fetch_enable;
    // arbiter to tracker
    logic                alloc_valid;
    logic [TAG_BITS-1:0] alloc_tag;
    owner_t              alloc_owner;
    // tracker to halt control
    logic                tracker_empty;

    //////////////////////////////
    // request path
    //////////////////////////////

    mem_request_arbiter #(
        .TAG_BITS (TAG_BITS)
    ) u_arbiter (
        .i_req_valid   (i_req_valid),
        .i_req_addr    (i_req_addr),
        .i_req_ready   (i_req_ready),
        .d_req_valid   (d_req_valid),
        .d_req_command (d_req_command),
        .d_req_addr    (d_req_addr),
        .d_req_data    (d_req_data),
        .d_req_ready   (d_req_ready),
        .fetch_enable  (fetch_enable),
        .mem_command   (mem_command),
        .mem_addr      (mem_addr),
        .mem_data      (mem_data),
        .mem_response  (mem_response),
        .alloc_valid   (alloc_valid),
        .alloc_tag     (alloc_tag),
        .alloc_owner   (alloc_owner)
    );

    //////////////////////////////
    // return path
    //////////////////////////////

    mem_tag_tracker #(
        .TAG_BITS (TAG_BITS)
    ) u_tracker (
        .clock         (clock),
        .reset         (reset),
        .alloc_valid   (alloc_valid),
        .alloc_tag     (alloc_tag),
        .alloc_owner   (alloc_owner),
        .mem_resp_tag  (mem_resp_tag),
        .mem_resp_data (mem_resp_data),
        .i_resp_valid  (i_resp_valid),
        .i_resp_data   (i_resp_data),
        .d_resp_valid  (d_resp_valid),
        .d_resp_data   (d_resp_data),
        .tracker_empty (tracker_empty)
    );

    // halt and drain
    mem_halt_control u_halt (
        .clock         (clock),
        .reset         (reset),
        .halt          (halt),
        .tracker_empty (tracker_empty),
        .d_req_valid   (d_req_valid),
        .fetch_enable  (fetch_enable),
        .halted        (halted)
    );

endmodule

// File: mem_port_sva.sv
`timescale 1ns/1ns

module mem_port_sva
    import mem_port_pkg::*;
#(
    parameter int TAG_BITS = 4
) (
    input logic                clock,
    input logic                reset,
    input logic                i_req_valid,
    input logic                d_req_valid,
    input logic                i_req_ready,
    input logic                d_req_ready,
    input bus_command_t        mem_command,
    input logic [TAG_BITS-1:0] mem_response
);

    // only one side transfers per cycle
    a_one_ready: assert property (@(posedge clock) disable iff (reset)
        !(i_req_ready && d_req_ready))
        else $error("both ready outputs high");

    // zero tag is a reject
    a_no_ready_on_reject: assert property (@(posedge clock) disable iff (reset)
        (mem_response == '0) |-> (!i_req_ready && !d_req_ready))
        else $error("ready high while mem_response is zero");

    // idle requesters leave the bus idle
    a_idle_bus: assert property (@(posedge clock) disable iff (reset)
        (!i_req_valid && !d_req_valid) |-> (mem_command == BUS_NONE))
        else $error("bus command without a valid request");

endmodule

bind mem_port mem_port_sva #(.TAG_BITS(TAG_BITS)) u_sva (.*);

// File: mem_port_tb.sv
`timescale 1ns/1ns

module mem_port_tb;
    import mem_port_pkg::*;

    localparam int TAG_BITS     = 4;
    localparam int CLK_PERIOD   = 4;
    localparam int REQ_LIMIT    = 50;
    // rough length of each test in cycles
    localparam int FETCH_CYCLES = 40;
    localparam int PRIO_CYCLES  = 50;
    localparam int REJ_CYCLES   = 60;
    localparam int MIX_CYCLES   = 150;
    localparam int HALT_CYCLES  = 100;
    localparam int WATCH_CYCLES =
        2 * (FETCH_CYCLES + PRIO_CYCLES + REJ_CYCLES + MIX_CYCLES + HALT_CYCLES);

    logic clock;
    logic reset;
    logic halt;
    logic i_req_valid;
    addr_t i_req_addr;
    logic i_req_ready;
    logic i_resp_valid;
    mem_data_t i_resp_data;
    logic d_req_valid;
    bus_command_t d_req_command;
    addr_t d_req_addr;
    mem_data_t d_req_data;
    logic d_req_ready;
    logic d_resp_valid;
    mem_data_t d_resp_data;
    bus_command_t mem_command;
    addr_t mem_addr;
    mem_data_t mem_data;
    logic [TAG_BITS-1:0] mem_response;
    mem_data_t mem_resp_data;
    logic [TAG_BITS-1:0] mem_resp_tag;
    logic halted;

    // memory model state
    logic [TAG_BITS-1:0] next_tag;
    logic reject;
    int base_delay;
    logic pend_valid [16];
    addr_t pend_addr [16];
    // address the requester asked for
    addr_t pend_exp [16];
    owner_t pend_owner [16];
    int pend_due [16];
    addr_t ret_addr;
    owner_t ret_owner;
    int now;
    int outstanding;
    int i_returns;
    int d_returns;

    int errors;
    int checks;
    int tests_run;

    mem_port #(
        .TAG_BITS (TAG_BITS)
    ) i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    //////////////////////////////
    // checking helpers
    //////////////////////////////

    task automatic check_value(input string msg, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic note_error(input string msg);
        errors++;
        $display("ERROR %0t ns: %s", $time, msg);
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        $display("test %s finished with %0d errors", name, errors - start_errors);
    endtask

    //////////////////////////////
    // memory model
    //////////////////////////////

    // accept with the current tag unless rejecting
    always_comb begin
        mem_response = '0;
        if (!reject && mem_command != BUS_NONE) begin
            mem_response = next_tag;
        end
    end

    always @(posedge clock) begin
        int pick;
        int live;
        if (reset) begin
            for (int t = 0; t < 16; t++) begin
                pend_valid[t] = 1'b0;
            end
            now = 0;
            next_tag <= 4'd1;
            mem_resp_tag <= '0;
            mem_resp_data <= '0;
            outstanding <= 0;
        end else begin
            now++;
            // return seen by the DUT in the cycle just ended
            if (mem_resp_tag != '0) begin
                if (ret_owner == OWNER_INSTR) begin
                    check_value("fetch return valid", 64'(i_resp_valid), 64'd1);
                    check_value("data valid on fetch return", 64'(d_resp_valid), 64'd0);
                    check_value("fetch return data", i_resp_data, {ret_addr, ~ret_addr});
                    i_returns <= i_returns + 1;
                end else begin
                    check_value("data return valid", 64'(d_resp_valid), 64'd1);
                    check_value("fetch valid on data return", 64'(i_resp_valid), 64'd0);
                    check_value("data return data", d_resp_data, {ret_addr, ~ret_addr});
                    d_returns <= d_returns + 1;
                end
            end else begin
                check_value("stray fetch return", 64'(i_resp_valid), 64'd0);
                check_value("stray data return", 64'(d_resp_valid), 64'd0);
            end
            // accept, stores are never returned
            if (mem_command != BUS_NONE && mem_response != '0) begin
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                if (mem_command == BUS_LOAD) begin
                    pend_valid[mem_response] = 1'b1;
                    pend_addr[mem_response]  = mem_addr;
                    // data side wins whenever it is valid
                    pend_owner[mem_response] = d_req_valid ? OWNER_DATA : OWNER_INSTR;
                    pend_exp[mem_response]   = d_req_valid ? d_req_addr : i_req_addr;
                    pend_due[mem_response]   = now + base_delay + int'($urandom % 6);
                end
            end
            // lowest due tag returns next
            pick = 0;
            for (int t = 1; t < 16; t++) begin
                if (pick == 0 && pend_valid[t] && pend_due[t] <= now) begin
                    pick = t;
                end
            end
            if (pick != 0) begin
                mem_resp_tag  <= TAG_BITS'(pick);
                mem_resp_data <= {pend_addr[pick], ~pend_addr[pick]};
                ret_addr      <= pend_exp[pick];
                ret_owner     <= pend_owner[pick];
                pend_valid[pick] = 1'b0;
            end else begin
                mem_resp_tag  <= '0;
                mem_resp_data <= '0;
            end
            live = (pick != 0) ? 1 : 0;
            for (int t = 1; t < 16; t++) begin
                if (pend_valid[t]) begin
                    live++;
                end
            end
            outstanding <= live;
        end
    end

    //////////////////////////////
    // requester tasks
    //////////////////////////////

    task automatic fetch(input addr_t addr);
        int n;
        @(posedge clock);
        i_req_valid <= 1'b1;
        i_req_addr  <= addr;
        n = 0;
        do begin
            @(posedge clock);
            n++;
        end while (!i_req_ready && n < REQ_LIMIT);
        if (!i_req_ready) begin
            note_error("fetch request was never accepted");
        end
        i_req_valid <= 1'b0;
    endtask

    task automatic data_request(input bus_command_t cmd, input addr_t addr,
                                input mem_data_t data);
        int n;
        @(posedge clock);
        d_req_valid   <= 1'b1;
        d_req_command <= cmd;
        d_req_addr    <= addr;
        d_req_data    <= data;
        n = 0;
        do begin
            @(posedge clock);
            n++;
        end while (!d_req_ready && n < REQ_LIMIT);
        if (!d_req_ready) begin
            note_error("data request was never accepted");
        end
        d_req_valid <= 1'b0;
    endtask

    // wait for the return counts, then make sure nothing extra arrives
    task automatic wait_returns(input int i_target, input int d_target);
        int n;
        n = 0;
        while ((i_returns < i_target || d_returns < d_target) && n < REQ_LIMIT) begin
            @(posedge clock);
            n++;
        end
        repeat (10) @(posedge clock);
        check_value("fetch return count", 64'(i_returns), 64'(i_target));
        check_value("data return count", 64'(d_returns), 64'(d_target));
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic test_fetch_alone();
        int e0;
        addr_t a;
        e0 = errors;
        a = addr_t'($urandom);
        check_value("ready low after reset", 64'(i_req_ready), 64'd0);
        check_value("bus idle after reset", 64'(mem_command), 64'(BUS_NONE));
        check_value("halted low after reset", 64'(halted), 64'd0);
        @(posedge clock);
        i_req_valid <= 1'b1;
        i_req_addr  <= a;
        @(posedge clock);
        check_value("fetch command", 64'(mem_command), 64'(BUS_LOAD));
        check_value("fetch address", 64'(mem_addr), 64'(a));
        check_value("fetch ready", 64'(i_req_ready), 64'd1);
        i_req_valid <= 1'b0;
        wait_returns(i_returns + 1, d_returns);
        finish_test("fetch_alone", e0);
    endtask

    task automatic test_priority_store();
        int e0;
        int i0;
        int d0;
        addr_t ia;
        addr_t da;
        e0 = errors;
        i0 = i_returns;
        d0 = d_returns;
        ia = addr_t'($urandom);
        da = addr_t'($urandom);
        @(posedge clock);
        i_req_valid   <= 1'b1;
        i_req_addr    <= ia;
        d_req_valid   <= 1'b1;
        d_req_command <= BUS_STORE;
        d_req_addr    <= da;
        d_req_data    <= {da, da};
        @(posedge clock);
        check_value("data wins the bus", 64'(mem_command), 64'(BUS_STORE));
        check_value("store address", 64'(mem_addr), 64'(da));
        check_value("store data", mem_data, {da, da});
        check_value("fetch held off", 64'(i_req_ready), 64'd0);
        check_value("store ready", 64'(d_req_ready), 64'd1);
        d_req_valid <= 1'b0;
        // held fetch goes out once the data side is idle
        @(posedge clock);
        check_value("held fetch command", 64'(mem_command), 64'(BUS_LOAD));
        check_value("held fetch address", 64'(mem_addr), 64'(ia));
        check_value("held fetch ready", 64'(i_req_ready), 64'd1);
        i_req_valid <= 1'b0;
        wait_returns(i0 + 1, d0);
        finish_test("priority_store", e0);
    endtask

    task automatic test_reject_retry();
        int e0;
        int i0;
        addr_t a;
        e0 = errors;
        i0 = i_returns;
        a = addr_t'($urandom);
        @(posedge clock);
        reject      <= 1'b1;
        i_req_valid <= 1'b1;
        i_req_addr  <= a;
        repeat (4) begin
            @(posedge clock);
            check_value("ready while rejected", 64'(i_req_ready), 64'd0);
        end
        // request stays up while the memory stops rejecting
        reject <= 1'b0;
        @(posedge clock);
        check_value("held fetch address", 64'(mem_addr), 64'(a));
        check_value("ready after reject clears", 64'(i_req_ready), 64'd1);
        i_req_valid <= 1'b0;
        wait_returns(i0 + 1, d_returns);
        finish_test("reject_retry", e0);
    endtask

    task automatic test_shuffled_returns();
        int e0;
        int i0;
        int d0;
        e0 = errors;
        i0 = i_returns;
        d0 = d_returns;
        for (int k = 0; k < 4; k++) begin
            fetch(addr_t'($urandom));
            data_request(BUS_LOAD, addr_t'($urandom), '0);
        end
        wait_returns(i0 + 4, d0 + 4);
        finish_test("shuffled_returns", e0);
    endtask

    task automatic test_halt_drain();
        int e0;
        int n;
        e0 = errors;
        base_delay <= 12;
        for (int k = 0; k < 3; k++) begin
            data_request(BUS_LOAD, addr_t'($urandom), '0);
        end
        @(posedge clock);
        halt        <= 1'b1;
        i_req_valid <= 1'b1;
        i_req_addr  <= addr_t'($urandom);
        n = 0;
        do begin
            @(posedge clock);
            n++;
            check_value("fetch blocked after halt", 64'(mem_command), 64'(BUS_NONE));
            check_value("fetch ready after halt", 64'(i_req_ready), 64'd0);
            if (outstanding > 0) begin
                check_value("halted while loads outstanding", 64'(halted), 64'd0);
            end
        end while (!halted && n < REQ_LIMIT);
        if (!halted) begin
            note_error("halted never rose after the loads drained");
        end
        check_value("loads left at halted", 64'(outstanding), 64'd0);
        i_req_valid <= 1'b0;
        finish_test("halt_drain", e0);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        void'($urandom(32'h0cecce2d));
        errors = 0;
        checks = 0;
        tests_run = 0;
        i_returns = 0;
        d_returns = 0;
        base_delay = 1;
        reject = 1'b0;
        reset = 1'b1;
        halt = 1'b0;
        i_req_valid = 1'b0;
        i_req_addr = '0;
        d_req_valid = 1'b0;
        d_req_command = BUS_NONE;
        d_req_addr = '0;
        d_req_data = '0;
        mem_resp_tag = '0;
        mem_resp_data = '0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        test_fetch_alone();
        test_priority_store();
        test_reject_retry();
        test_shuffled_returns();
        test_halt_drain();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCH_CYCLES * CLK_PERIOD);
        $display("simulation timed out before the tests finished");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_port_tb
FILELIST  ?= mem_port.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failures found
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: mem_port.f
mem_port_pkg.sv
mem_request_arbiter.sv
mem_tag_tracker.sv
mem_halt_control.sv
mem_port.sv
mem_port_sva.sv
mem_port_tb.sv
